/* drac_exe_pkg.sv */
`default_nettype none

package drac_exe_pkg;

    // ---------------------------------------------------------------------
    // Widths and divider iteration counts
    // ---------------------------------------------------------------------
    localparam int unsigned XLEN         = 64;
    localparam int unsigned DIV_STEPS_64 = 64;
    localparam int unsigned DIV_STEPS_32 = 32;
    localparam int unsigned CNT_W        = 7;
    localparam int unsigned REG_ADDR_W   = 5;

    typedef logic [XLEN-1:0]       bus64_t;
    typedef logic [39:0]           addr_pc_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    typedef enum logic [1:0] {
        UNIT_ALU,
        UNIT_BRANCH,
        UNIT_DIV
    } unit_t;

    typedef enum logic [4:0] {
        // ALU
        ADD, SUB, AND, OR, XOR, SLL, SRL, SRA, SLT, SLTU,
        // Branch and jump
        BEQ, BNE, BLT, BGE, BLTU, BGEU, JAL, JALR,
        // Divide
        DIV, DIVU, REM, REMU
    } instr_type_t;

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        FIX
    } div_state_t;

    // Upper and lower halves of a data word, for W forms
    typedef struct packed {
        logic [31:0] hi;
        logic [31:0] lo;
    } word_halves_t;

    typedef union packed {
        bus64_t       full;
        word_halves_t w;
    } operand_u;

    // ---------------------------------------------------------------------
    // Stage records
    // ---------------------------------------------------------------------
    typedef struct packed {
        logic        valid;
        addr_pc_t    pc;
        unit_t       unit;
        instr_type_t instr_type;
        logic        op_32;
        logic        use_imm;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        reg_addr_t   rd;
        bus64_t      imm;
    } instr_t;

    typedef struct packed {
        instr_t instr;
        bus64_t data_rs1;
        bus64_t data_rs2;
    } rr_exe_instr_t;

    // Write-back value, also the bypass source
    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        bus64_t    data;
    } wb_exe_instr_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        bus64_t    result_rd;
        addr_pc_t  result_pc;
        logic      branch_taken;
    } exe_wb_instr_t;

endpackage

`default_nettype wire

/* exe_alu.sv */
`default_nettype none

module exe_alu (
    input  wire drac_exe_pkg::bus64_t      data_rs1_i,
    input  wire drac_exe_pkg::bus64_t      data_rs2_i,
    input  wire drac_exe_pkg::instr_type_t instr_type_i,
    input  wire                            op_32_i,
    output drac_exe_pkg::bus64_t           result_o
);

    drac_exe_pkg::operand_u a;
    drac_exe_pkg::operand_u b;
    drac_exe_pkg::operand_u res;
    drac_exe_pkg::bus64_t   r64;
    logic [31:0]            r32;

    always_comb begin
        a.full = data_rs1_i;
        b.full = data_rs2_i;
        r64    = '0;
        r32    = '0;
        case (instr_type_i)
            drac_exe_pkg::ADD: begin
                r64 = a.full + b.full;
                r32 = a.w.lo + b.w.lo;
            end
            drac_exe_pkg::SUB: begin
                r64 = a.full - b.full;
                r32 = a.w.lo - b.w.lo;
            end
            drac_exe_pkg::AND: begin
                r64 = a.full & b.full;
                r32 = a.w.lo & b.w.lo;
            end
            drac_exe_pkg::OR: begin
                r64 = a.full | b.full;
                r32 = a.w.lo | b.w.lo;
            end
            drac_exe_pkg::XOR: begin
                r64 = a.full ^ b.full;
                r32 = a.w.lo ^ b.w.lo;
            end
            // Shift amounts are 6 bits wide, 5 for W forms
            drac_exe_pkg::SLL: begin
                r64 = a.full << b.full[5:0];
                r32 = a.w.lo << b.w.lo[4:0];
            end
            drac_exe_pkg::SRL: begin
                r64 = a.full >> b.full[5:0];
                r32 = a.w.lo >> b.w.lo[4:0];
            end
            drac_exe_pkg::SRA: begin
                r64 = $signed(a.full) >>> b.full[5:0];
                r32 = $signed(a.w.lo) >>> b.w.lo[4:0];
            end
            drac_exe_pkg::SLT: begin
                r64 = {63'b0, $signed(a.full) < $signed(b.full)};
                r32 = {31'b0, $signed(a.w.lo) < $signed(b.w.lo)};
            end
            drac_exe_pkg::SLTU: begin
                r64 = {63'b0, a.full < b.full};
                r32 = {31'b0, a.w.lo < b.w.lo};
            end
            default: begin
                r64 = '0;
                r32 = '0;
            end
        endcase

        if (op_32_i) begin
            res.w.lo = r32;
            res.w.hi = {32{r32[31]}};
        end else begin
            res.full = r64;
        end
    end

    assign result_o = res.full;

    // Known operands never yield an unknown result
    always_comb begin
        if (!$isunknown({data_rs1_i, data_rs2_i, instr_type_i, op_32_i})) begin
            assert final (!$isunknown(result_o))
                else $error("ALU result unknown for known inputs");
        end
    end

endmodule

`default_nettype wire

/* exe_branch_unit.sv */
`default_nettype none

module exe_branch_unit (
    input  wire drac_exe_pkg::instr_type_t instr_type_i,
    input  wire drac_exe_pkg::addr_pc_t    pc_i,
    input  wire drac_exe_pkg::bus64_t      data_rs1_i,
    input  wire drac_exe_pkg::bus64_t      data_rs2_i,
    input  wire drac_exe_pkg::bus64_t      imm_i,
    output logic                           taken_o,
    output drac_exe_pkg::addr_pc_t         target_o,
    output drac_exe_pkg::bus64_t           link_o
);

    drac_exe_pkg::bus64_t   rs1_plus_imm;
    drac_exe_pkg::addr_pc_t pc_plus_imm;
    drac_exe_pkg::addr_pc_t pc_plus_4;

    always_comb begin
        case (instr_type_i)
            drac_exe_pkg::BEQ:  taken_o = (data_rs1_i == data_rs2_i);
            drac_exe_pkg::BNE:  taken_o = (data_rs1_i != data_rs2_i);
            drac_exe_pkg::BLT:  taken_o = ($signed(data_rs1_i) < $signed(data_rs2_i));
            drac_exe_pkg::BGE:  taken_o = ($signed(data_rs1_i) >= $signed(data_rs2_i));
            drac_exe_pkg::BLTU: taken_o = (data_rs1_i < data_rs2_i);
            drac_exe_pkg::BGEU: taken_o = (data_rs1_i >= data_rs2_i);
            // Jumps are unconditional
            drac_exe_pkg::JAL,
            drac_exe_pkg::JALR: taken_o = 1'b1;
            default:            taken_o = 1'b0;
        endcase
    end

    assign rs1_plus_imm = data_rs1_i + imm_i;
    assign pc_plus_imm  = pc_i + imm_i[39:0];
    assign pc_plus_4    = pc_i + 40'd4;

    // JALR target has bit 0 cleared
    assign target_o = (instr_type_i == drac_exe_pkg::JALR) ?
                      {rs1_plus_imm[39:1], 1'b0} : pc_plus_imm;

    assign link_o = {{(drac_exe_pkg::XLEN - 40){1'b0}}, pc_plus_4};

endmodule

`default_nettype wire

/* div_control.sv */
`default_nettype none

module div_control (
    input  wire                       clk_i,
    input  wire                       arst_n_i,
    input  wire                       kill_i,
    input  wire                       start_i,
    input  wire                       last_i,
    output drac_exe_pkg::div_state_t  state_o,
    output logic                      stall_o,
    output logic                      done_o
);

    drac_exe_pkg::div_state_t state_q;
    drac_exe_pkg::div_state_t state_d;

    always_comb begin
        state_d = state_q;
        case (state_q)
            drac_exe_pkg::IDLE: if (start_i) state_d = drac_exe_pkg::RUN;
            drac_exe_pkg::RUN:  if (last_i)  state_d = drac_exe_pkg::FIX;
            drac_exe_pkg::FIX:  state_d = drac_exe_pkg::IDLE;
            default:            state_d = drac_exe_pkg::IDLE;
        endcase
        // Abort takes priority over any transition
        if (kill_i) begin
            state_d = drac_exe_pkg::IDLE;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= drac_exe_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign state_o = state_q;

    // Stall covers the start cycle and all iterations
    assign stall_o = ((state_q == drac_exe_pkg::IDLE) && start_i) ||
                     (state_q == drac_exe_pkg::RUN);
    assign done_o  = (state_q == drac_exe_pkg::FIX);

    a_done_single: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        done_o |=> !done_o
    ) else $error("Divider done held for two cycles");

    a_no_idle_to_fix: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        (state_q == drac_exe_pkg::IDLE) |=> (state_q != drac_exe_pkg::FIX)
    ) else $error("Divider jumped from IDLE to FIX");

endmodule

`default_nettype wire

/* div_step_counter.sv */
`default_nettype none

module div_step_counter (
    input  wire  clk_i,
    input  wire  arst_n_i,
    input  wire  load_i,
    input  wire  op_32_i,
    input  wire  step_i,
    output logic last_o
);

    logic [drac_exe_pkg::CNT_W-1:0] cnt_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cnt_q <= '0;
        end else if (load_i) begin
            cnt_q <= op_32_i ? drac_exe_pkg::CNT_W'(drac_exe_pkg::DIV_STEPS_32) :
                               drac_exe_pkg::CNT_W'(drac_exe_pkg::DIV_STEPS_64);
        end else if (step_i) begin
            cnt_q <= cnt_q - 1'b1;
        end
    end

    // Final iteration is the one taken with a single step left
    assign last_o = (cnt_q == drac_exe_pkg::CNT_W'(1));

    a_no_step_at_zero: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        step_i |-> (cnt_q != '0)
    ) else $error("Divider stepped with no iterations left");

endmodule

`default_nettype wire

/* div_datapath.sv */
`default_nettype none

module div_datapath (
    input  wire                            clk_i,
    input  wire                            arst_n_i,
    input  wire drac_exe_pkg::div_state_t  state_i,
    input  wire                            load_i,
    input  wire drac_exe_pkg::instr_type_t instr_type_i,
    input  wire                            op_32_i,
    input  wire drac_exe_pkg::bus64_t      dvnd_i,
    input  wire drac_exe_pkg::bus64_t      dvsr_i,
    output drac_exe_pkg::bus64_t           result_o
);

    localparam int unsigned W = drac_exe_pkg::XLEN;

    drac_exe_pkg::operand_u a_in;
    drac_exe_pkg::operand_u b_in;
    drac_exe_pkg::operand_u res;
    drac_exe_pkg::bus64_t   a_ext, b_ext, a_mag, b_mag;
    drac_exe_pkg::bus64_t   rem_q, quo_q, dvsr_q, dvnd_q;
    drac_exe_pkg::bus64_t   quo_fix, rem_fix;
    logic                   signed_op, a_neg, b_neg, ge;
    logic                   neg_quo_q, neg_rem_q, is_rem_q, op_32_q, dz_q;
    logic [W:0]             rem_sh, diff;

    // ---------------------------------------------------------------------
    // Operand decode and magnitudes
    // ---------------------------------------------------------------------
    always_comb begin
        a_in.full = dvnd_i;
        b_in.full = dvsr_i;
        signed_op = (instr_type_i == drac_exe_pkg::DIV) ||
                    (instr_type_i == drac_exe_pkg::REM);
        if (op_32_i) begin
            a_ext = {{32{signed_op & a_in.w.lo[31]}}, a_in.w.lo};
            b_ext = {{32{signed_op & b_in.w.lo[31]}}, b_in.w.lo};
        end else begin
            a_ext = a_in.full;
            b_ext = b_in.full;
        end
        a_neg = signed_op & a_ext[W-1];
        b_neg = signed_op & b_ext[W-1];
        a_mag = a_neg ? -a_ext : a_ext;
        b_mag = b_neg ? -b_ext : b_ext;
    end

    // One restoring step, remainder always fits in W bits afterwards
    assign rem_sh = {rem_q, quo_q[W-1]};
    assign diff   = rem_sh - {1'b0, dvsr_q};
    assign ge     = ~diff[W];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            neg_quo_q <= 1'b0;
            neg_rem_q <= 1'b0;
            is_rem_q  <= 1'b0;
            op_32_q   <= 1'b0;
            dz_q      <= 1'b0;
        end else if (load_i) begin
            neg_quo_q <= a_neg ^ b_neg;
            neg_rem_q <= a_neg;
            is_rem_q  <= (instr_type_i == drac_exe_pkg::REM) ||
                         (instr_type_i == drac_exe_pkg::REMU);
            op_32_q   <= op_32_i;
            dz_q      <= (b_ext == '0);
        end
    end

    always_ff @(posedge clk_i) begin
        if (load_i) begin
            rem_q  <= '0;
            // W forms start with the dividend in the upper half
            quo_q  <= op_32_i ? {a_mag[31:0], 32'b0} : a_mag;
            dvsr_q <= b_mag;
            dvnd_q <= a_ext;
        end else if (state_i == drac_exe_pkg::RUN) begin
            rem_q <= ge ? diff[W-1:0] : rem_sh[W-1:0];
            quo_q <= {quo_q[W-2:0], ge};
        end
    end

    // ---------------------------------------------------------------------
    // Sign and divide-by-zero correction
    // ---------------------------------------------------------------------
    always_comb begin
        quo_fix = neg_quo_q ? -quo_q : quo_q;
        rem_fix = neg_rem_q ? -rem_q : rem_q;
        if (dz_q) begin
            quo_fix = '1;
            rem_fix = dvnd_q;
        end
        res.full = is_rem_q ? rem_fix : quo_fix;
        if (op_32_q) begin
            res.w.hi = {32{res.w.lo[31]}};
        end
    end

    assign result_o = res.full;

endmodule

`default_nettype wire

/* exe_top.sv */
`default_nettype none

module exe_top (
    input  wire                              clk_i,
    input  wire                              arst_n_i,
    input  wire                              kill_i,
    input  wire drac_exe_pkg::rr_exe_instr_t from_rr_i,
    input  wire drac_exe_pkg::wb_exe_instr_t from_wb_i,
    output drac_exe_pkg::exe_wb_instr_t      to_wb_o,
    output logic                             stall_o
);

    drac_exe_pkg::instr_t     instr;
    drac_exe_pkg::bus64_t     rs1_data_bypass;
    drac_exe_pkg::bus64_t     rs2_data_bypass;
    drac_exe_pkg::bus64_t     rs2_data_def;

    drac_exe_pkg::bus64_t     result_alu;
    drac_exe_pkg::bus64_t     result_div;
    logic                     taken_branch;
    drac_exe_pkg::addr_pc_t   target_branch;
    drac_exe_pkg::bus64_t     link_branch;

    drac_exe_pkg::div_state_t div_state;
    logic                     div_start;
    logic                     div_last;
    logic                     div_done;

    assign instr = from_rr_i.instr;

    // ---------------------------------------------------------------------
    // Write-back bypass, x0 is never forwarded
    // ---------------------------------------------------------------------
    assign rs1_data_bypass = (from_wb_i.valid && (from_wb_i.rd == instr.rs1) &&
                              (instr.rs1 != '0)) ? from_wb_i.data : from_rr_i.data_rs1;
    assign rs2_data_bypass = (from_wb_i.valid && (from_wb_i.rd == instr.rs2) &&
                              (instr.rs2 != '0)) ? from_wb_i.data : from_rr_i.data_rs2;

    assign rs2_data_def = instr.use_imm ? instr.imm : rs2_data_bypass;

    exe_alu i_alu (
        .data_rs1_i   (rs1_data_bypass),
        .data_rs2_i   (rs2_data_def),
        .instr_type_i (instr.instr_type),
        .op_32_i      (instr.op_32),
        .result_o     (result_alu)
    );

    exe_branch_unit i_branch (
        .instr_type_i (instr.instr_type),
        .pc_i         (instr.pc),
        .data_rs1_i   (rs1_data_bypass),
        .data_rs2_i   (rs2_data_bypass),
        .imm_i        (instr.imm),
        .taken_o      (taken_branch),
        .target_o     (target_branch),
        .link_o       (link_branch)
    );

    // Divider accepts a new operation only while idle
    assign div_start = instr.valid && (instr.unit == drac_exe_pkg::UNIT_DIV) &&
                       (div_state == drac_exe_pkg::IDLE) && !kill_i;

    div_control i_div_control (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .kill_i   (kill_i),
        .start_i  (div_start),
        .last_i   (div_last),
        .state_o  (div_state),
        .stall_o  (stall_o),
        .done_o   (div_done)
    );

    div_step_counter i_div_counter (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .load_i   (div_start),
        .op_32_i  (instr.op_32),
        .step_i   (div_state == drac_exe_pkg::RUN),
        .last_o   (div_last)
    );

    div_datapath i_div_datapath (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .state_i      (div_state),
        .load_i       (div_start),
        .instr_type_i (instr.instr_type),
        .op_32_i      (instr.op_32),
        .dvnd_i       (rs1_data_bypass),
        .dvsr_i       (rs2_data_def),
        .result_o     (result_div)
    );

    // ---------------------------------------------------------------------
    // Result record to write-back
    // ---------------------------------------------------------------------
    always_comb begin
        to_wb_o.rd           = instr.rd;
        to_wb_o.result_pc    = '0;
        to_wb_o.branch_taken = 1'b0;
        // A divide is only valid on its done pulse
        to_wb_o.valid = instr.valid && !stall_o &&
                        ((instr.unit != drac_exe_pkg::UNIT_DIV) || div_done);
        case (instr.unit)
            drac_exe_pkg::UNIT_ALU: to_wb_o.result_rd = result_alu;
            drac_exe_pkg::UNIT_DIV: to_wb_o.result_rd = result_div;
            drac_exe_pkg::UNIT_BRANCH: begin
                to_wb_o.result_rd    = link_branch;
                to_wb_o.result_pc    = target_branch;
                to_wb_o.branch_taken = taken_branch;
            end
            default: to_wb_o.result_rd = '0;
        endcase
    end

endmodule

`default_nettype wire

/* tb_exe_top.sv */
`default_nettype none

module tb_exe_top;

    localparam int unsigned DIV_TIMEOUT = 100;

    logic                        clk;
    logic                        arst_n;
    logic                        kill;
    drac_exe_pkg::rr_exe_instr_t from_rr;
    drac_exe_pkg::wb_exe_instr_t from_wb;
    drac_exe_pkg::exe_wb_instr_t to_wb;
    logic                        stall;

    // Expected response of the instruction on the inputs
    string                       test_name;
    logic                        exp_valid;
    drac_exe_pkg::reg_addr_t     exp_rd;
    drac_exe_pkg::bus64_t        exp_result;
    drac_exe_pkg::addr_pc_t      exp_pc;
    logic                        exp_taken;
    int unsigned                 exp_stall;
    int unsigned                 stall_run;
    int                          seed;

    exe_top i_dut (
        .clk_i     (clk),
        .arst_n_i  (arst_n),
        .kill_i    (kill),
        .from_rr_i (from_rr),
        .from_wb_i (from_wb),
        .to_wb_o   (to_wb),
        .stall_o   (stall)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Consecutive cycles with stall high
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            stall_run <= 0;
        end else begin
            stall_run <= stall ? stall_run + 1 : 0;
        end
    end

    task automatic show_mismatch(input string field, input logic [63:0] exp,
                                 input logic [63:0] act);
        $display("[ERROR] test %s, %s: expected %h, actual %h", test_name, field, exp, act);
        $display("*** FAILED ***");
        $fatal(1, "Mismatch on %s", field);
    endtask

    task automatic abort_run(input string what);
        $display("Test %s: %s", test_name, what);
        $display("*** FAILED ***");
        $fatal(1, "%s", what);
    endtask

    // ------------------------------------------------------------------------
    // Reference models
    // ------------------------------------------------------------------------
    function automatic drac_exe_pkg::bus64_t sext32(input logic [31:0] v);
        return {{32{v[31]}}, v};
    endfunction

    function automatic drac_exe_pkg::bus64_t alu_model(input drac_exe_pkg::instr_type_t op,
                                                       input drac_exe_pkg::bus64_t a,
                                                       input drac_exe_pkg::bus64_t b,
                                                       input logic w);
        drac_exe_pkg::bus64_t x, y, r;
        logic [5:0]           sh;
        x  = w ? sext32(a[31:0]) : a;
        y  = w ? sext32(b[31:0]) : b;
        sh = w ? {1'b0, b[4:0]} : b[5:0];
        case (op)
            drac_exe_pkg::ADD:  r = x + y;
            drac_exe_pkg::SUB:  r = x - y;
            drac_exe_pkg::AND:  r = x & y;
            drac_exe_pkg::OR:   r = x | y;
            drac_exe_pkg::XOR:  r = x ^ y;
            drac_exe_pkg::SLL:  r = x << sh;
            drac_exe_pkg::SRL:  r = (w ? {32'b0, a[31:0]} : a) >> sh;
            drac_exe_pkg::SRA:  r = $signed(x) >>> sh;
            drac_exe_pkg::SLT:  r = $signed(x) < $signed(y);
            default:            r = x < y;
        endcase
        return w ? sext32(r[31:0]) : r;
    endfunction

    function automatic logic taken_model(input drac_exe_pkg::instr_type_t op,
                                         input drac_exe_pkg::bus64_t a,
                                         input drac_exe_pkg::bus64_t b);
        case (op)
            drac_exe_pkg::BEQ:  return a == b;
            drac_exe_pkg::BNE:  return a != b;
            drac_exe_pkg::BLT:  return $signed(a) < $signed(b);
            drac_exe_pkg::BGE:  return !($signed(a) < $signed(b));
            drac_exe_pkg::BLTU: return a < b;
            drac_exe_pkg::BGEU: return !(a < b);
            default:            return 1'b1;
        endcase
    endfunction

    function automatic drac_exe_pkg::bus64_t div_model(input drac_exe_pkg::instr_type_t op,
                                                       input drac_exe_pkg::bus64_t a,
                                                       input drac_exe_pkg::bus64_t b,
                                                       input logic w);
        drac_exe_pkg::bus64_t x, y, q, r, res, most_neg;
        logic                 sgn;
        sgn      = (op == drac_exe_pkg::DIV) || (op == drac_exe_pkg::REM);
        x        = w ? (sgn ? sext32(a[31:0]) : {32'b0, a[31:0]}) : a;
        y        = w ? (sgn ? sext32(b[31:0]) : {32'b0, b[31:0]}) : b;
        most_neg = w ? 64'hffff_ffff_8000_0000 : 64'h8000_0000_0000_0000;
        if (y == '0) begin
            q = '1;
            r = x;
        end else if (sgn && (x == most_neg) && (y == '1)) begin
            q = most_neg;
            r = '0;
        end else if (sgn) begin
            q = $signed(x) / $signed(y);
            r = $signed(x) % $signed(y);
        end else begin
            q = x / y;
            r = x % y;
        end
        res = ((op == drac_exe_pkg::REM) || (op == drac_exe_pkg::REMU)) ? r : q;
        return w ? sext32(res[31:0]) : res;
    endfunction

    // Operand as seen after the write-back bypass
    function automatic drac_exe_pkg::bus64_t forwarded(input drac_exe_pkg::reg_addr_t idx,
                                                       input drac_exe_pkg::bus64_t rr_data);
        if (from_wb.valid && (from_wb.rd == idx) && (idx != '0)) begin
            return from_wb.data;
        end
        return rr_data;
    endfunction

    // ------------------------------------------------------------------------
    // Stimulus helpers
    // ------------------------------------------------------------------------
    function automatic drac_exe_pkg::bus64_t random_word();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic int unsigned pick(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic drac_exe_pkg::instr_type_t nth_op(input drac_exe_pkg::instr_type_t base,
                                                         input int unsigned k);
        return drac_exe_pkg::instr_type_t'(int'(base) + k);
    endfunction

    task automatic random_instr(input drac_exe_pkg::unit_t unit,
                                input drac_exe_pkg::instr_type_t op);
        drac_exe_pkg::bus64_t rw;
        rw = random_word();
        from_rr.instr.valid      = 1'b1;
        from_rr.instr.pc         = {rw[37:0], 2'b00};
        from_rr.instr.unit       = unit;
        from_rr.instr.instr_type = op;
        from_rr.instr.op_32      = (unit != drac_exe_pkg::UNIT_BRANCH) && (pick(2) == 1);
        from_rr.instr.use_imm    = 1'b0;
        from_rr.instr.rs1        = 1 + pick(31);
        from_rr.instr.rs2        = 1 + pick(31);
        from_rr.instr.rd         = pick(32);
        rw = random_word();
        from_rr.instr.imm = {{51{rw[12]}}, rw[12:0]};
        from_rr.data_rs1  = random_word();
        from_rr.data_rs2  = random_word();
    endtask

    task automatic set_expected(input string name);
        drac_exe_pkg::instr_t ins;
        drac_exe_pkg::bus64_t a, b_reg, b, tgt;
        ins        = from_rr.instr;
        a          = forwarded(ins.rs1, from_rr.data_rs1);
        b_reg      = forwarded(ins.rs2, from_rr.data_rs2);
        b          = ins.use_imm ? ins.imm : b_reg;
        tgt        = a + ins.imm;
        test_name  = name;
        exp_valid  = ins.valid;
        exp_rd     = ins.rd;
        exp_pc     = '0;
        exp_taken  = 1'b0;
        exp_stall  = 0;
        case (ins.unit)
            drac_exe_pkg::UNIT_ALU: exp_result = alu_model(ins.instr_type, a, b, ins.op_32);
            drac_exe_pkg::UNIT_BRANCH: begin
                exp_result = {24'b0, ins.pc + 40'd4};
                exp_taken  = taken_model(ins.instr_type, a, b_reg);
                exp_pc     = (ins.instr_type == drac_exe_pkg::JALR) ?
                             {tgt[39:1], 1'b0} : ins.pc + ins.imm[39:0];
            end
            default: begin
                exp_result = div_model(ins.instr_type, a, b, ins.op_32);
                // Start cycle plus one per iteration
                exp_stall  = ins.op_32 ? 33 : 65;
            end
        endcase
    endtask

    task automatic present_instr(input string name);
        int unsigned waited;
        set_expected(name);
        if (from_rr.instr.unit != drac_exe_pkg::UNIT_DIV) begin
            @(negedge clk);
        end else begin
            waited = 0;
            do begin
                @(negedge clk);
                waited++;
            end while (stall && (waited < DIV_TIMEOUT));
            // Hold through the FIX cycle so its result is sampled
            if (stall) begin
                abort_run("stall_o did not fall within the timeout");
            end else begin
                @(negedge clk);
            end
        end
    endtask

    // ------------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------------
    a_result: assert property (@(posedge clk) disable iff (!arst_n)
        to_wb.valid |-> (to_wb.result_rd == exp_result)
    ) else show_mismatch("result_rd", $sampled(exp_result), $sampled(to_wb.result_rd));

    a_rd: assert property (@(posedge clk) disable iff (!arst_n)
        to_wb.valid |-> (to_wb.rd == exp_rd)
    ) else show_mismatch("rd", $sampled(exp_rd), $sampled(to_wb.rd));

    a_pc: assert property (@(posedge clk) disable iff (!arst_n)
        to_wb.valid |-> (to_wb.result_pc == exp_pc)
    ) else show_mismatch("result_pc", $sampled(exp_pc), $sampled(to_wb.result_pc));

    a_taken: assert property (@(posedge clk) disable iff (!arst_n)
        to_wb.valid |-> (to_wb.branch_taken == exp_taken)
    ) else show_mismatch("branch_taken", $sampled(exp_taken), $sampled(to_wb.branch_taken));

    a_valid: assert property (@(posedge clk) disable iff (!arst_n)
        (exp_valid && !stall) |-> to_wb.valid
    ) else abort_run("to_wb_o.valid is low for a completed instruction");

    a_quiet: assert property (@(posedge clk) disable iff (!arst_n)
        stall |-> !to_wb.valid
    ) else abort_run("to_wb_o.valid is high during a divider stall");

    a_stall_len: assert property (@(posedge clk) disable iff (!arst_n)
        (!stall && (stall_run != 0) && (exp_stall != 0)) |-> (stall_run == exp_stall)
    ) else show_mismatch("stall cycles", $sampled(exp_stall), $sampled(stall_run));

    a_kill: assert property (@(posedge clk) disable iff (!arst_n)
        (kill && stall) |=> !stall
    ) else abort_run("stall_o is still high the cycle after kill_i");

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------
    initial begin
        seed       = 32'hdc98;
        arst_n     = 1'b0;
        kill       = 1'b0;
        from_rr    = '0;
        from_wb    = '0;
        test_name  = "reset";
        exp_valid  = 1'b0;
        exp_rd     = '0;
        exp_result = '0;
        exp_pc     = '0;
        exp_taken  = 1'b0;
        exp_stall  = 0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        for (int i = 0; i < 200; i++) begin
            random_instr(drac_exe_pkg::UNIT_ALU, nth_op(drac_exe_pkg::ADD, pick(10)));
            from_rr.instr.use_imm = (pick(4) == 0);
            present_instr("alu_random");
        end

        // Forwarding into rs1, rs2, both, never from x0
        for (int i = 0; i < 40; i++) begin
            random_instr(drac_exe_pkg::UNIT_ALU, nth_op(drac_exe_pkg::ADD, pick(10)));
            from_wb.valid = 1'b1;
            from_wb.data  = random_word();
            case (i % 5)
                0: from_wb.rd = from_rr.instr.rs1;
                1: from_wb.rd = from_rr.instr.rs2;
                2: begin
                    from_rr.instr.rs2 = from_rr.instr.rs1;
                    from_wb.rd        = from_rr.instr.rs1;
                end
                3: begin
                    from_rr.instr.rs1 = '0;
                    from_rr.instr.rs2 = '0;
                    from_wb.rd        = '0;
                end
                default: begin
                    from_wb.rd            = from_rr.instr.rs2;
                    from_rr.instr.use_imm = 1'b1;
                end
            endcase
            present_instr("bypass");
        end
        from_wb = '0;

        for (int i = 0; i < 160; i++) begin
            random_instr(drac_exe_pkg::UNIT_BRANCH, nth_op(drac_exe_pkg::BEQ, i % 8));
            if (pick(2) == 0) begin
                from_rr.data_rs2 = from_rr.data_rs1;
            end
            present_instr("branch");
        end

        for (int i = 0; i < 40; i++) begin
            random_instr(drac_exe_pkg::UNIT_DIV, nth_op(drac_exe_pkg::DIV, pick(4)));
            from_rr.data_rs2 = from_rr.data_rs2 >> pick(64);
            present_instr("div_random");
        end

        for (int k = 0; k < 4; k++) begin
            for (int w = 0; w < 2; w++) begin
                random_instr(drac_exe_pkg::UNIT_DIV, nth_op(drac_exe_pkg::DIV, k));
                from_rr.instr.op_32 = (w != 0);
                from_rr.data_rs2    = '0;
                present_instr("div_by_zero");
                random_instr(drac_exe_pkg::UNIT_DIV, nth_op(drac_exe_pkg::DIV, k));
                from_rr.instr.op_32 = (w != 0);
                from_rr.data_rs1    = (w != 0) ? {from_rr.data_rs1[63:32], 32'h8000_0000} :
                                                 64'h8000_0000_0000_0000;
                from_rr.data_rs2    = '1;
                present_instr("div_overflow");
            end
        end

        // Abort a division mid-run, then check the next one
        for (int i = 0; i < 2; i++) begin
            random_instr(drac_exe_pkg::UNIT_DIV, drac_exe_pkg::DIVU);
            from_rr.instr.op_32 = (i != 0);
            set_expected("kill");
            repeat (10) @(negedge clk);
            kill                = 1'b1;
            from_rr.instr.valid = 1'b0;
            exp_valid           = 1'b0;
            exp_stall           = 0;
            @(negedge clk);
            kill = 1'b0;
            @(negedge clk);
            random_instr(drac_exe_pkg::UNIT_DIV, drac_exe_pkg::DIV);
            present_instr("after_kill");
        end

        from_rr   = '0;
        exp_valid = 1'b0;
        repeat (4) @(negedge clk);
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
drac_exe_pkg.sv
exe_alu.sv
exe_branch_unit.sv
div_control.sv
div_step_counter.sv
div_datapath.sv
exe_top.sv
tb_exe_top.sv

/* Bender.yml */
package:
  name: drac_exe

sources:
  - drac_exe_pkg.sv
  - exe_alu.sv
  - exe_branch_unit.sv
  - div_control.sv
  - div_step_counter.sv
  - div_datapath.sv
  - exe_top.sv
  - target: test
    files:
      - tb_exe_top.sv
